// File: src.f
mipsPkg.sv
instrDecode.sv
execute.sv
resultStage.sv
pipeTop.sv
tbClock.sv
pipeTb.sv

// File: Bender.yml
package:
  name: mipsPipe

sources:
  - mipsPkg.sv
  - instrDecode.sv
  - execute.sv
  - resultStage.sv
  - pipeTop.sv
  - target: test
    files:
      - tbClock.sv
      - pipeTb.sv

// File: pipeTb.sv
`timescale 1ns/10ps
`default_nettype none

module pipeTb;
	import mipsPkg::*;

	logic     clk;
	logic     arstN;
	word_t    instr;
	logic     instrValid;
	logic     instrReady;
	logic     wbValid;
	regAddr_t wbReg;
	word_t    wbData;

	word_t    regs [32];	// Architectural state of the model
	word_t    mem [MemWords];
	regAddr_t expRegQ [$];
	word_t    expDataQ [$];
	int       expEdgeQ [$];	// Acceptance edge per entry
	logic     headOk;
	regAddr_t headReg;
	word_t    headData;
	int       headEdge;
	int       cycleCnt = 0;
	int       errCnt;
	int       passCnt;
	int       failCnt;
	int       seed;

	tbClock clkGen (.clk(clk), .arstN(arstN));

	pipeTop dut (
		.clk(clk), .arstN(arstN),
		.instr(instr), .instrValid(instrValid), .instrReady(instrReady),
		.wbValid(wbValid), .wbReg(wbReg), .wbData(wbData)
	);

	always @(posedge clk) cycleCnt <= cycleCnt + 1;	// Rising edges so far

	function automatic void refreshHead();
		headOk = expRegQ.size() > 0;
		if (headOk) begin
			headReg  = expRegQ[0];
			headData = expDataQ[0];
			headEdge = expEdgeQ[0];
		end
	endfunction

	// Head retires on its writeback or once overdue
	always @(posedge clk) begin
		if (arstN && headOk && (wbValid || cycleCnt >= headEdge + 2)) begin
			void'(expRegQ.pop_front());
			void'(expDataQ.pop_front());
			void'(expEdgeQ.pop_front());
			refreshHead();
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Writeback checks
	////////////////////////////////////////////////////////////////////////////

	assert property (@(posedge clk) disable iff (!arstN) wbValid |-> headOk)
	else begin
		$display("Unexpected writeback to r%0d at %0t", $sampled(wbReg), $time);
		errCnt++;
	end

	assert property (@(posedge clk) disable iff (!arstN) (wbValid && headOk) |-> wbReg == headReg)
	else begin
		$display("Fail %0t wbReg expected %0d got %0d", $time, $sampled(headReg), $sampled(wbReg));
		errCnt++;
	end

	assert property (@(posedge clk) disable iff (!arstN) (wbValid && headOk) |-> wbData == headData)
	else begin
		$display("Fail %0t wbData expected %h got %h", $time, $sampled(headData),
			$sampled(wbData));
		errCnt++;
	end

	// Three edges from acceptance to writeback
	assert property (@(posedge clk) disable iff (!arstN)
		(wbValid && headOk) |-> cycleCnt == headEdge + 2)
	else begin
		$display("Fail %0t wbValid edge expected %0d got %0d", $time, $sampled(headEdge) + 2,
			$sampled(cycleCnt));
		errCnt++;
	end

	assert property (@(posedge clk) disable iff (!arstN)
		(headOk && cycleCnt == headEdge + 2) |-> wbValid)
	else begin
		$display("Writeback of r%0d missing at %0t", $sampled(headReg), $time);
		errCnt++;
	end

	////////////////////////////////////////////////////////////////////////////
	// Stimulus and model
	////////////////////////////////////////////////////////////////////////////

	function automatic word_t encR(field_t fn, regAddr_t rd, regAddr_t rs, regAddr_t rt);
		return {OpRType, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic word_t encI(field_t op, regAddr_t rt, regAddr_t rs, logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	task automatic abortRun(input string why);
		$display("Timeout at %0t, %s", $time, why);
		$display("** FAIL **");
		$finish;
	endtask

	// Architectural effect in program order
	task automatic model(input word_t ins, input int accEdge);
		regAddr_t dest;
		word_t    a;
		word_t    b;
		word_t    imm;
		word_t    addr;
		word_t    res;
		logic     wr;
		a    = regs[ins[25:21]];
		b    = regs[ins[20:16]];
		imm  = {{16{ins[15]}}, ins[15:0]};
		addr = a + imm;	// Word index in bits 5:2
		dest = ins[20:16];
		wr   = 1'b1;
		res  = '0;
		case (field_t'(ins[31:26]))
			OpRType: begin
				dest = ins[15:11];
				case (field_t'(ins[5:0]))
					FnAdd:   res = a + b;
					FnSub:   res = a - b;
					FnAnd:   res = a & b;
					FnOr:    res = a | b;
					FnSlt:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					default: wr = 1'b0;
				endcase
			end
			OpAddi: res = a + imm;
			OpLw:   res = mem[addr[5:2]];
			OpSw: begin
				mem[addr[5:2]] = b;
				wr = 1'b0;
			end
			default: wr = 1'b0;	// No-op
		endcase
		if (wr && dest != '0) begin
			regs[dest] = res;
			expRegQ.push_back(dest);
			expDataQ.push_back(res);
			expEdgeQ.push_back(accEdge);
			refreshHead();
		end
	endtask

	// Called on a falling edge, returns on the falling edge after acceptance
	task automatic issue(input word_t ins, input int expStalls = -1);
		int stalls;
		stalls     = 0;
		instr      = ins;
		instrValid = 1'b1;
		#1;
		while (!instrReady) begin
			stalls++;
			if (stalls > 8) abortRun("instrReady stuck low");
			@(negedge clk);
			#1;
		end
		model(ins, cycleCnt + 1);
		@(negedge clk);
		instrValid = 1'b0;
		if (expStalls >= 0) begin
			assert (stalls == expStalls)
			else begin
				$display("Fail %0t instrReady stall cycles expected %0d got %0d", $time,
					expStalls, stalls);
				errCnt++;
			end
		end
	endtask

	task automatic endTest(input string name, input int errBefore);
		int n;
		n = 0;
		while (expRegQ.size() > 0) begin
			@(negedge clk);
			n++;
			if (n > 20) abortRun("writeback queue never drained");
		end
		repeat (3) @(negedge clk);	// Room for a stray writeback
		if (errCnt == errBefore) begin
			passCnt++;
			$display("Test %s passed", name);
		end else begin
			failCnt++;
			$display("Test %s failed with %0d errors", name, errCnt - errBefore);
		end
	endtask

	function automatic word_t randInstr();
		regAddr_t rs;
		regAddr_t rt;
		regAddr_t rd;
		logic [15:0] imm;
		rs  = 5'($random(seed) & 7);	// r0 to r7
		rt  = 5'($random(seed) & 7);
		rd  = 5'($random(seed) & 7);
		imm = 16'($random(seed));
		case ($random(seed) & 7)
			0:       return encR(FnAdd, rd, rs, rt);
			1:       return encR(FnSub, rd, rs, rt);
			2:       return encR(FnAnd, rd, rs, rt);
			3:       return encR(FnOr, rd, rs, rt);
			4:       return encR(FnSlt, rd, rs, rt);
			5:       return encI(OpAddi, rt, rs, imm);
			6:       return encI(OpLw, rt, rs, imm);
			default: return encI(OpSw, rt, rs, imm);
		endcase
	endfunction

	initial begin
		int e;
		int n;
		instr      = '0;
		instrValid = 1'b0;
		errCnt     = 0;
		passCnt    = 0;
		failCnt    = 0;
		seed       = 32'h5c71;
		for (int i = 0; i < 32; i++) regs[i] = '0;
		for (int i = 0; i < MemWords; i++) mem[i] = '0;
		refreshHead();
		n = 0;
		while (arstN !== 1'b1) begin
			@(negedge clk);
			n++;
			if (n > 20) abortRun("reset never released");
		end
		@(negedge clk);

		// Dependent ALU chain, both forwarding sources
		e = errCnt;
		issue(encI(OpAddi, 1, 0, 16'd25));
		issue(encI(OpAddi, 2, 0, -16'sd7));
		issue(encR(FnAdd, 3, 1, 2));
		issue(encR(FnSub, 4, 3, 1));
		issue(encR(FnAnd, 5, 4, 3));
		issue(encR(FnOr, 6, 5, 2));
		issue(encR(FnSlt, 7, 2, 1));	// Negative below positive
		issue(encR(FnSlt, 8, 1, 2));
		issue(encR(FnSlt, 9, 7, 2));
		endTest("alu chain", e);

		// Immediates and write-through read
		e = errCnt;
		issue(encI(OpAddi, 10, 0, 16'h7fff));
		issue(encI(OpAddi, 11, 10, 16'h8000));
		issue(encI(OpAddi, 12, 11, -16'sd1));
		issue(encI(OpAddi, 13, 0, 16'd5));
		issue(encI(OpAddi, 20, 0, 16'd1));
		issue(encI(OpAddi, 21, 0, 16'd2));
		issue(encR(FnAdd, 14, 13, 13));	// r13 on writeback this cycle
		endTest("addi", e);

		// Stores and loads
		e = errCnt;
		issue(encI(OpSw, 1, 0, 16'd8));
		issue(encI(OpSw, 2, 0, 16'd12));
		issue(encI(OpLw, 15, 0, 16'd8));
		issue(encI(OpLw, 16, 0, 16'd12));
		issue(encI(OpAddi, 17, 0, 16'd64));
		issue(encI(OpSw, 3, 17, -16'sd60));
		issue(encI(OpLw, 18, 0, 16'd4));
		issue(encI(OpLw, 19, 0, 16'd72));	// Aliases word 2
		endTest("memory", e);

		// Load-use interlock
		e = errCnt;
		issue(encI(OpLw, 20, 0, 16'd8));
		issue(encR(FnAdd, 21, 20, 1), 1);
		issue(encI(OpLw, 22, 0, 16'd12));
		issue(encI(OpAddi, 23, 1, 16'd3), 0);
		issue(encI(OpLw, 24, 0, 16'd8));
		issue(encI(OpSw, 24, 0, 16'd16), 1);	// Store data from the load
		issue(encI(OpLw, 25, 0, 16'd16));
		endTest("load use", e);

		// Register 0 and unsupported encodings
		e = errCnt;
		issue(encI(OpAddi, 0, 0, 16'd99));
		issue(encR(FnAdd, 0, 1, 2));
		issue(encI(6'h3F, 5, 1, 16'h1234));
		issue(encR(6'h00, 5, 1, 2));
		issue(encR(FnAdd, 26, 0, 0));
		issue(encI(OpAddi, 27, 0, 16'd5));
		issue(encR(FnOr, 28, 0, 1));
		issue(encI(OpLw, 0, 0, 16'd8));
		issue(encR(FnAdd, 29, 0, 1), 0);
		endTest("register zero", e);

		// Random stream with gaps
		e = errCnt;
		for (int i = 0; i < 300; i++) begin
			issue(randInstr());
			repeat ($random(seed) & 3) @(negedge clk);
		end
		endTest("random stream", e);

		$display("Tests passed %0d failed %0d", passCnt, failCnt);
		if (failCnt == 0 && errCnt == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: tbClock.sv
`timescale 1ns/10ps
`default_nettype none

module tbClock (
	output logic clk,
	output logic arstN
);
	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;	// 20 ns period
	end

	// Reset held for 8 cycles, released away from the rising edge
	initial begin
		arstN = 1'b0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		arstN = 1'b1;
	end

endmodule

`default_nettype wire

// File: pipeTop.sv
`timescale 1ns/10ps
`default_nettype none

module pipeTop (
	input  wire                clk,
	input  wire                arstN,
	input  wire mipsPkg::word_t    instr,
	input  wire                instrValid,
	output logic               instrReady,
	output logic               wbValid,
	output mipsPkg::regAddr_t  wbReg,
	output mipsPkg::word_t     wbData
);
	import mipsPkg::*;

	////////////////////////////////////////////////////////////////////////////
	// Stage wiring
	////////////////////////////////////////////////////////////////////////////

	// Decode to execute
	logic     dxValid;
	aluOp_t   dxAluOp;
	word_t    dxOpA;
	word_t    dxOpB;
	word_t    dxImm;
	logic     dxUseImm;
	regAddr_t dxRs;
	regAddr_t dxRt;
	regAddr_t dxDest;
	logic     dxWrite;
	logic     dxLoad;
	logic     dxStore;

	// Execute to result
	logic     xrValid;
	word_t    xrResult;
	word_t    xrStoreData;
	regAddr_t xrDest;
	logic     xrWrite;
	logic     xrLoad;
	logic     xrStore;

	instrDecode decode0 (
		.clk(clk), .arstN(arstN),
		.instr(instr), .instrValid(instrValid), .instrReady(instrReady),
		.wbValid(wbValid), .wbReg(wbReg), .wbData(wbData),	// Register file write
		.dxValid(dxValid), .dxAluOp(dxAluOp), .dxOpA(dxOpA), .dxOpB(dxOpB),
		.dxImm(dxImm), .dxUseImm(dxUseImm), .dxRs(dxRs), .dxRt(dxRt),
		.dxDest(dxDest), .dxWrite(dxWrite), .dxLoad(dxLoad), .dxStore(dxStore)
	);

	execute execute0 (
		.clk(clk), .arstN(arstN),
		.dxValid(dxValid), .dxAluOp(dxAluOp), .dxOpA(dxOpA), .dxOpB(dxOpB),
		.dxRs(dxRs), .dxRt(dxRt), .dxImm(dxImm), .dxUseImm(dxUseImm),
		.dxDest(dxDest), .dxWrite(dxWrite), .dxLoad(dxLoad), .dxStore(dxStore),
		.xrFwdDest(xrDest), .xrFwdWrite(xrWrite), .xrFwdResult(xrResult),	// First forward source
		.wbValid(wbValid), .wbReg(wbReg), .wbData(wbData),	// Second forward source
		.xrValid(xrValid), .xrResult(xrResult), .xrStoreData(xrStoreData),
		.xrDest(xrDest), .xrWrite(xrWrite), .xrLoad(xrLoad), .xrStore(xrStore)
	);

	resultStage result0 (
		.clk(clk), .arstN(arstN),
		.xrValid(xrValid), .xrResult(xrResult), .xrStoreData(xrStoreData),
		.xrDest(xrDest), .xrWrite(xrWrite), .xrLoad(xrLoad), .xrStore(xrStore),
		.wbValid(wbValid), .wbReg(wbReg), .wbData(wbData)
	);

endmodule

`default_nettype wire

// File: resultStage.sv
`timescale 1ns/10ps
`default_nettype none

module resultStage (
	input  wire                clk,
	input  wire                arstN,
	input  wire                xrValid,
	input  wire mipsPkg::word_t    xrResult,
	input  wire mipsPkg::word_t    xrStoreData,
	input  wire mipsPkg::regAddr_t xrDest,
	input  wire                xrWrite,
	input  wire                xrLoad,
	input  wire                xrStore,
	output logic               wbValid,
	output mipsPkg::regAddr_t  wbReg,
	output mipsPkg::word_t     wbData
);
	import mipsPkg::*;

	word_t    dataMem [MemWords];
	memAddr_t memAddr;
	word_t    loadWord;
	word_t    resultSel;

	////////////////////////////////////////////////////////////////////////////
	// Data memory
	////////////////////////////////////////////////////////////////////////////

	assign memAddr = xrResult[MemAddrWidth+1:2];	// Word aligned, bits 5:2

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < MemWords; i++) begin
				dataMem[i] <= '0;
			end
		end else if (xrValid && xrStore) begin
			dataMem[memAddr] <= xrStoreData;
		end
	end

	assign loadWord = dataMem[memAddr];	// Async read

	// Writeback mux
	assign resultSel = xrLoad ? loadWord : xrResult;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			wbValid <= 1'b0;
		end else begin
			wbValid <= xrValid && xrWrite;	// Stores and no-ops stay quiet
		end
	end

	always_ff @(posedge clk) begin
		wbReg  <= xrDest;
		wbData <= resultSel;
	end

	// Destination r0 is filtered back in decode
	assert property (@(posedge clk) disable iff (!arstN) wbValid |-> wbReg != '0)
		else $error("Writeback to register 0");

endmodule

`default_nettype wire

// File: execute.sv
`timescale 1ns/10ps
`default_nettype none

module execute (
	input  wire                clk,
	input  wire                arstN,
	input  wire                dxValid,
	input  wire mipsPkg::aluOp_t   dxAluOp,
	input  wire mipsPkg::word_t    dxOpA,
	input  wire mipsPkg::word_t    dxOpB,
	input  wire mipsPkg::regAddr_t dxRs,
	input  wire mipsPkg::regAddr_t dxRt,
	input  wire mipsPkg::word_t    dxImm,
	input  wire                dxUseImm,
	input  wire mipsPkg::regAddr_t dxDest,
	input  wire                dxWrite,
	input  wire                dxLoad,
	input  wire                dxStore,
	input  wire mipsPkg::regAddr_t xrFwdDest,
	input  wire                xrFwdWrite,
	input  wire mipsPkg::word_t    xrFwdResult,
	input  wire                wbValid,
	input  wire mipsPkg::regAddr_t wbReg,
	input  wire mipsPkg::word_t    wbData,
	output logic               xrValid,
	output mipsPkg::word_t     xrResult,
	output mipsPkg::word_t     xrStoreData,
	output mipsPkg::regAddr_t  xrDest,
	output logic               xrWrite,
	output logic               xrLoad,
	output logic               xrStore
);
	import mipsPkg::*;

	word_t fwdA;
	word_t fwdB;
	word_t aluB;
	word_t aluRes;
	logic  rtUsed;

	// Newest producer wins, loads in xr have no data yet
	function automatic word_t fwdSel(regAddr_t src, word_t decoded);
		if (xrFwdWrite && !xrLoad && xrFwdDest == src) begin
			return xrFwdResult;
		end else if (wbValid && wbReg == src) begin
			return wbData;
		end
		return decoded;
	endfunction

	always_comb begin
		fwdA = fwdSel(dxRs, dxOpA);
		fwdB = fwdSel(dxRt, dxOpB);
	end

	assign aluB = dxUseImm ? dxImm : fwdB;

	////////////////////////////////////////////////////////////////////////////
	// ALU
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		case (dxAluOp)
			AluAdd:  aluRes = fwdA + aluB;
			AluSub:  aluRes = fwdA - aluB;
			AluAnd:  aluRes = fwdA & aluB;
			AluOr:   aluRes = fwdA | aluB;
			AluSlt:  aluRes = ($signed(fwdA) < $signed(aluB)) ? word_t'(1) : '0;
			default: aluRes = aluB;		// Pass
		endcase
	end

	// Execute/result register
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			xrValid <= 1'b0;
			xrWrite <= 1'b0;
			xrLoad  <= 1'b0;
			xrStore <= 1'b0;
		end else begin
			xrValid <= dxValid;
			xrWrite <= dxValid && dxWrite;
			xrLoad  <= dxValid && dxLoad;
			xrStore <= dxValid && dxStore;
		end
	end

	always_ff @(posedge clk) begin
		xrResult    <= aluRes;	// ALU value or memory address
		xrStoreData <= fwdB;
		xrDest      <= dxDest;
	end

	// R-type and SW read rt
	assign rtUsed = !dxUseImm || dxStore;

	// Decode must have held back any consumer of this load
	assert property (@(posedge clk) disable iff (!arstN)
		(xrValid && xrLoad && xrWrite && dxValid && (dxWrite || dxStore)) |->
		!(xrDest == dxRs || (rtUsed && xrDest == dxRt)))
		else $error("Load-use hazard reached execute");

endmodule

`default_nettype wire

// File: instrDecode.sv
`timescale 1ns/10ps
`default_nettype none

module instrDecode (
	input  wire                clk,
	input  wire                arstN,
	input  wire mipsPkg::word_t    instr,
	input  wire                instrValid,
	output logic               instrReady,
	input  wire                wbValid,
	input  wire mipsPkg::regAddr_t wbReg,
	input  wire mipsPkg::word_t    wbData,
	output logic               dxValid,
	output mipsPkg::aluOp_t    dxAluOp,
	output mipsPkg::word_t     dxOpA,
	output mipsPkg::word_t     dxOpB,
	output mipsPkg::word_t     dxImm,
	output logic               dxUseImm,
	output mipsPkg::regAddr_t  dxRs,
	output mipsPkg::regAddr_t  dxRt,
	output mipsPkg::regAddr_t  dxDest,
	output logic               dxWrite,
	output logic               dxLoad,
	output logic               dxStore
);
	import mipsPkg::*;

	field_t   opcode;
	field_t   funct;
	regAddr_t rs;
	regAddr_t rt;
	regAddr_t rd;
	word_t    immExt;
	word_t    rsVal;
	word_t    rtVal;
	word_t    regFile [2**RegAddrWidth];

	aluOp_t   decOp;
	regAddr_t decDest;
	logic     decUseImm;
	logic     decWrite;
	logic     decLoad;
	logic     decStore;
	logic     usesRt;	// rt is a source operand
	logic     loadUse;
	logic     accept;

	// Instruction fields
	assign opcode = instr[31:26];
	assign rs     = instr[25:21];
	assign rt     = instr[20:16];
	assign rd     = instr[15:11];
	assign funct  = instr[5:0];
	assign immExt = {{16{instr[15]}}, instr[15:0]};	// Sign extended

	////////////////////////////////////////////////////////////////////////////
	// Register file
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < 2**RegAddrWidth; i++) begin
				regFile[i] <= '0;
			end
		end else if (wbValid && wbReg != '0) begin	// r0 stays zero
			regFile[wbReg] <= wbData;
		end
	end

	// Write-through read
	assign rsVal = (wbValid && wbReg == rs && rs != '0) ? wbData : regFile[rs];
	assign rtVal = (wbValid && wbReg == rt && rt != '0) ? wbData : regFile[rt];

	// Opcode and funct to control
	always_comb begin
		decOp     = AluPass;
		decDest   = rt;
		decUseImm = 1'b0;
		decWrite  = 1'b0;
		decLoad   = 1'b0;
		decStore  = 1'b0;
		usesRt    = 1'b0;
		case (opcode)
			OpRType: begin
				decDest  = rd;
				usesRt   = 1'b1;
				decWrite = 1'b1;
				case (funct)
					FnAdd:   decOp = AluAdd;
					FnSub:   decOp = AluSub;
					FnAnd:   decOp = AluAnd;
					FnOr:    decOp = AluOr;
					FnSlt:   decOp = AluSlt;
					default: decWrite = 1'b0;	// Unknown funct retires silently
				endcase
			end
			OpAddi: begin
				decOp     = AluAdd;
				decUseImm = 1'b1;
				decWrite  = 1'b1;
			end
			OpLw: begin
				decOp     = AluAdd;	// Address = rs + imm
				decUseImm = 1'b1;
				decWrite  = 1'b1;
				decLoad   = 1'b1;
			end
			OpSw: begin
				decOp     = AluAdd;
				decUseImm = 1'b1;
				decStore  = 1'b1;
				usesRt    = 1'b1;	// Store data
			end
			default: ;
		endcase
		decWrite = decWrite && (decDest != '0);
	end

	// Load-use interlock against the load now in execute
	assign loadUse    = dxValid && dxLoad && dxWrite &&
	                    ((dxDest == rs) || (usesRt && dxDest == rt));
	assign instrReady = !(instrValid && loadUse);
	assign accept     = instrValid && instrReady;

	////////////////////////////////////////////////////////////////////////////
	// Decode/execute register
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			dxValid <= 1'b0;
			dxWrite <= 1'b0;
			dxLoad  <= 1'b0;
			dxStore <= 1'b0;
		end else begin
			dxValid <= accept;	// Bubble on stall or idle
			dxWrite <= accept && decWrite;
			dxLoad  <= accept && decLoad;
			dxStore <= accept && decStore;
		end
	end

	always_ff @(posedge clk) begin
		dxAluOp  <= decOp;
		dxOpA    <= rsVal;
		dxOpB    <= rtVal;
		dxImm    <= immExt;
		dxUseImm <= decUseImm;
		dxRs     <= rs;
		dxRt     <= rt;
		dxDest   <= decDest;
	end

	// Stall lasts one cycle since the bubble clears the hazard
	assert property (@(posedge clk) disable iff (!arstN) !instrReady |=> instrReady)
		else $error("instrReady low for two cycles");

endmodule

`default_nettype wire

// File: mipsPkg.sv
`default_nettype none

package mipsPkg;

	////////////////////////////////////////////////////////////////////////////
	// Widths
	////////////////////////////////////////////////////////////////////////////

	localparam int WordWidth    = 32;
	localparam int RegAddrWidth = 5;	// 32 architectural registers
	localparam int FieldWidth   = 6;	// Opcode and funct fields
	localparam int MemWords     = 16;	// Data memory depth in words
	localparam int MemAddrWidth = $clog2(MemWords);

	typedef logic [WordWidth-1:0]    word_t;
	typedef logic [RegAddrWidth-1:0] regAddr_t;
	typedef logic [MemAddrWidth-1:0] memAddr_t;	// Word index, byte bits dropped
	typedef logic [FieldWidth-1:0]   field_t;

	////////////////////////////////////////////////////////////////////////////
	// Encodings
	////////////////////////////////////////////////////////////////////////////

	// Primary opcodes, instr[31:26]
	localparam field_t OpRType = 6'h00;	// Function in instr[5:0]
	localparam field_t OpAddi  = 6'h08;
	localparam field_t OpLw    = 6'h23;
	localparam field_t OpSw    = 6'h2B;

	// R-type function codes
	localparam field_t FnAdd = 6'h20;
	localparam field_t FnSub = 6'h22;
	localparam field_t FnAnd = 6'h24;
	localparam field_t FnOr  = 6'h25;
	localparam field_t FnSlt = 6'h2A;

	// ALU operation selected in decode
	typedef enum logic [2:0] {
		AluAdd,
		AluSub,
		AluAnd,
		AluOr,
		AluSlt,		// Signed compare, 0 or 1
		AluPass		// Operand B through, no-op slot
	} aluOp_t;

endpackage

`default_nettype wire
